// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_ADDR_W = 12;  // 4096 words

    localparam logic [XLEN-1:0] UART_TX_ADDR = 32'h0002_0020;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;   // srl / sra by funct7
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT = 7'b010_0000;  // sub, sra, srai

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0] byte_t;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_AUIPC  = 7'b001_0111,
        OPC_STORE  = 7'b010_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111
    } opcode_e;

    // one value per executed operation
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } alu_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } mem_size_e;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode (
    input  rv_pkg::word_t    i_inst,
    output rv_pkg::alu_op_e  o_op,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    output rv_pkg::reg_idx_t o_rd,
    output rv_pkg::word_t    o_imm
);
    import rv_pkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign o_rd = i_inst[11:7];
    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];

    // immediate format follows the opcode, shamt lands in imm[4:0]
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: o_imm = {i_inst[31:12], 12'h000};
            OPC_JAL: o_imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                              i_inst[30:21], 1'b0};
            OPC_BRANCH: o_imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25],
                                 i_inst[11:8], 1'b0};
            OPC_STORE: o_imm = {{21{i_inst[31]}}, i_inst[30:25], i_inst[11:7]};
            default: o_imm = {{21{i_inst[31]}}, i_inst[30:20]};  // I type
        endcase
    end

    always_comb begin
        o_op = OP_NOP;  // fence, system and anything unknown
        case (opcode)
            OPC_LUI: o_op = OP_LUI;
            OPC_AUIPC: o_op = OP_AUIPC;
            OPC_JAL: o_op = OP_JAL;
            OPC_JALR: if (funct3 == 3'b000) o_op = OP_JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000: o_op = OP_BEQ;
                    3'b001: o_op = OP_BNE;
                    3'b100: o_op = OP_BLT;
                    3'b101: o_op = OP_BGE;
                    3'b110: o_op = OP_BLTU;
                    3'b111: o_op = OP_BGEU;
                    default: ;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000: o_op = OP_LB;
                    3'b001: o_op = OP_LH;
                    3'b010: o_op = OP_LW;
                    3'b100: o_op = OP_LBU;
                    3'b101: o_op = OP_LHU;
                    default: ;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000: o_op = OP_SB;
                    3'b001: o_op = OP_SH;
                    3'b010: o_op = OP_SW;
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD: o_op = OP_ADDI;
                    F3_SLT: o_op = OP_SLTI;
                    F3_SLTU: o_op = OP_SLTIU;
                    F3_XOR: o_op = OP_XORI;
                    F3_OR: o_op = OP_ORI;
                    F3_AND: o_op = OP_ANDI;
                    F3_SLL: if (funct7 == F7_BASE) o_op = OP_SLLI;
                    F3_SR: begin
                        if (funct7 == F7_BASE) o_op = OP_SRLI;
                        else if (funct7 == F7_ALT) o_op = OP_SRAI;
                    end
                    default: ;
                endcase
            end
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD: o_op = OP_ADD;
                        F3_SLL: o_op = OP_SLL;
                        F3_SLT: o_op = OP_SLT;
                        F3_SLTU: o_op = OP_SLTU;
                        F3_XOR: o_op = OP_XOR;
                        F3_SR: o_op = OP_SRL;
                        F3_OR: o_op = OP_OR;
                        default: o_op = OP_AND;
                    endcase
                end else if (funct7 == F7_ALT) begin
                    if (funct3 == F3_ADD) o_op = OP_SUB;
                    else if (funct3 == F3_SR) o_op = OP_SRA;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::alu_op_e   i_op,
    input  rv_pkg::word_t     i_imm,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    output rv_pkg::word_t     o_pc,
    output rv_pkg::word_t     o_result,
    output logic              o_wb_en,
    output logic              o_load,
    output rv_pkg::mem_size_e o_load_size,
    output logic              o_load_signed,
    output logic              o_store_en,
    output rv_pkg::mem_size_e o_store_size,
    output rv_pkg::word_t     o_store_data,
    output rv_pkg::word_t     o_mem_byte_addr,
    output logic              o_uart_en,
    output rv_pkg::byte_t     o_uart_data
);
    import rv_pkg::*;

    word_t pc_plus4;
    word_t pc_target;   // branch, jal, auipc
    word_t addr_sum;    // loads, stores, jalr
    word_t op_b;
    word_t next_pc;
    logic use_imm;
    logic eq;
    logic lt_s;
    logic lt_u;
    logic take;
    logic uart_hit;

    assign use_imm = i_op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
                                  OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI};
    assign op_b = use_imm ? i_imm : i_rs2_data;

    assign pc_plus4 = o_pc + word_t'(4);
    assign pc_target = o_pc + i_imm;
    assign addr_sum = i_rs1_data + i_imm;

    assign eq = (i_rs1_data == op_b);
    assign lt_s = $signed(i_rs1_data) < $signed(op_b);
    assign lt_u = i_rs1_data < op_b;

    always_comb begin
        case (i_op)
            OP_ADD, OP_ADDI: o_result = i_rs1_data + op_b;
            OP_SUB: o_result = i_rs1_data - op_b;
            OP_AND, OP_ANDI: o_result = i_rs1_data & op_b;
            OP_OR, OP_ORI: o_result = i_rs1_data | op_b;
            OP_XOR, OP_XORI: o_result = i_rs1_data ^ op_b;
            OP_SLL, OP_SLLI: o_result = i_rs1_data << op_b[4:0];
            OP_SRL, OP_SRLI: o_result = i_rs1_data >> op_b[4:0];
            OP_SRA, OP_SRAI: o_result = word_t'($signed(i_rs1_data) >>> op_b[4:0]);
            OP_SLT, OP_SLTI: o_result = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU, OP_SLTIU: o_result = {{(XLEN-1){1'b0}}, lt_u};
            OP_LUI: o_result = i_imm;
            OP_AUIPC: o_result = pc_target;
            OP_JAL, OP_JALR: o_result = pc_plus4;  // link address
            default: o_result = '0;
        endcase
    end

    always_comb begin
        case (i_op)
            OP_BEQ: take = eq;
            OP_BNE: take = !eq;
            OP_BLT: take = lt_s;
            OP_BGE: take = !lt_s;
            OP_BLTU: take = lt_u;
            OP_BGEU: take = !lt_u;
            OP_JAL, OP_JALR: take = 1'b1;
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        if (!take) next_pc = pc_plus4;
        else if (i_op == OP_JALR) next_pc = {addr_sum[XLEN-1:1], 1'b0};
        else next_pc = pc_target;
    end

    assign o_wb_en = !(i_op inside {OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                    OP_BLTU, OP_BGEU, OP_SB, OP_SH, OP_SW});

    // memory side
    assign o_mem_byte_addr = addr_sum;
    assign o_store_data = i_rs2_data;
    assign o_load = i_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign o_load_signed = i_op inside {OP_LB, OP_LH};
    assign o_load_size = (i_op inside {OP_LB, OP_LBU}) ? SIZE_B :
                         (i_op inside {OP_LH, OP_LHU}) ? SIZE_H : SIZE_W;
    assign o_store_en = i_op inside {OP_SB, OP_SH, OP_SW};
    assign o_store_size = (i_op == OP_SB) ? SIZE_B :
                          (i_op == OP_SH) ? SIZE_H : SIZE_W;

    assign uart_hit = (i_op == OP_SB) && (addr_sum == UART_TX_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            o_pc <= RESET_PC;
            o_uart_en <= 1'b0;
        end else begin
            o_pc <= next_pc;
            o_uart_en <= uart_hit;  // one cycle per byte store
        end
    end

    always_ff @(posedge clk) begin
        if (uart_hit) o_uart_data <= i_rs2_data[7:0];
    end

endmodule

// ==== src/rv_mem.sv ====
`timescale 1ns/100ps

module rv_mem (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_load_en,
    input  rv_pkg::mem_addr_t i_load_addr,
    input  rv_pkg::word_t     i_load_data,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::word_t     i_byte_addr,
    input  logic              i_store_en,
    input  rv_pkg::mem_size_e i_store_size,
    input  rv_pkg::word_t     i_store_data,
    output rv_pkg::word_t     o_inst,
    output rv_pkg::word_t     o_rdata
);
    import rv_pkg::*;

    word_t mem [0:(1 << MEM_ADDR_W) - 1];

    mem_addr_t inst_addr;
    mem_addr_t data_addr;
    logic [3:0] lane_en;
    word_t lane_data;  // store bytes copied to every lane

    // upper address bits are dropped, so the memory image repeats
    assign inst_addr = i_pc[MEM_ADDR_W+1:2];
    assign data_addr = i_byte_addr[MEM_ADDR_W+1:2];

    assign o_inst = mem[inst_addr];
    assign o_rdata = mem[data_addr];

    always_comb begin
        case (i_store_size)
            SIZE_B: begin
                lane_en = 4'b0001 << i_byte_addr[1:0];
                lane_data = {4{i_store_data[7:0]}};
            end
            SIZE_H: begin
                lane_en = 4'b0011 << {i_byte_addr[1], 1'b0};
                lane_data = {2{i_store_data[15:0]}};
            end
            default: begin
                lane_en = 4'b1111;
                lane_data = i_store_data;
            end
        endcase
    end

    // program load only under reset, core stores only after it
    always_ff @(posedge clk) begin
        if (reset) begin
            if (i_load_en) mem[i_load_addr] <= i_load_data;
        end else if (i_store_en) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) mem[data_addr][8*b +: 8] <= lane_data[8*b +: 8];
            end
        end
    end

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/100ps

module rv_result (
    input  logic              clk,
    input  rv_pkg::reg_idx_t  i_rs1,
    input  rv_pkg::reg_idx_t  i_rs2,
    input  rv_pkg::reg_idx_t  i_rd,
    input  logic              i_wb_en,
    input  logic              i_load,
    input  rv_pkg::mem_size_e i_load_size,
    input  logic              i_load_signed,
    input  rv_pkg::word_t     i_byte_addr,
    input  rv_pkg::word_t     i_rdata,
    input  rv_pkg::word_t     i_result,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31];  // no storage for x0
    word_t shifted;
    word_t load_data;
    word_t wb_data;

    // addressed byte or half moved down to bit 0
    assign shifted = i_rdata >> {i_byte_addr[1:0], 3'b000};

    always_comb begin
        case (i_load_size)
            SIZE_B: load_data = {{(XLEN-8){i_load_signed & shifted[7]}}, shifted[7:0]};
            SIZE_H: load_data = {{(XLEN-16){i_load_signed & shifted[15]}}, shifted[15:0]};
            default: load_data = i_rdata;
        endcase
    end

    assign wb_data = i_load ? load_data : i_result;

    always_ff @(posedge clk) begin
        if (i_wb_en && (i_rd != '0)) regs[i_rd] <= wb_data;
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_load_en,
    input  rv_pkg::mem_addr_t i_load_addr,
    input  rv_pkg::word_t     i_load_data,
    output logic              o_uart_en,
    output rv_pkg::byte_t     o_uart_data
);
    import rv_pkg::*;

    word_t pc;
    word_t inst;
    alu_op_e op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t imm;
    word_t rs1_data;
    word_t rs2_data;
    word_t result;
    logic wb_en;
    logic load;
    mem_size_e load_size;
    logic load_signed;
    logic store_en;
    mem_size_e store_size;
    word_t store_data;
    word_t byte_addr;
    word_t rdata;

    rv_decode u_decode (
        .i_inst (inst),
        .o_op   (op),
        .o_rs1  (rs1),
        .o_rs2  (rs2),
        .o_rd   (rd),
        .o_imm  (imm)
    );

    rv_execute u_execute (
        .clk             (clk),
        .reset           (reset),
        .i_op            (op),
        .i_imm           (imm),
        .i_rs1_data      (rs1_data),
        .i_rs2_data      (rs2_data),
        .o_pc            (pc),
        .o_result        (result),
        .o_wb_en         (wb_en),
        .o_load          (load),
        .o_load_size     (load_size),
        .o_load_signed   (load_signed),
        .o_store_en      (store_en),
        .o_store_size    (store_size),
        .o_store_data    (store_data),
        .o_mem_byte_addr (byte_addr),
        .o_uart_en       (o_uart_en),
        .o_uart_data     (o_uart_data)
    );

    rv_mem u_mem (
        .clk          (clk),
        .reset        (reset),
        .i_load_en    (i_load_en),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .i_pc         (pc),
        .i_byte_addr  (byte_addr),
        .i_store_en   (store_en),
        .i_store_size (store_size),
        .i_store_data (store_data),
        .o_inst       (inst),
        .o_rdata      (rdata)
    );

    rv_result u_result (
        .clk           (clk),
        .i_rs1         (rs1),
        .i_rs2         (rs2),
        .i_rd          (rd),
        .i_wb_en       (wb_en),
        .i_load        (load),
        .i_load_size   (load_size),
        .i_load_signed (load_signed),
        .i_byte_addr   (byte_addr),
        .i_rdata       (rdata),
        .i_result      (result),
        .o_rs1_data    (rs1_data),
        .o_rs2_data    (rs2_data)
    );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;  // 40 ns period
    end

    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

// ==== testbench/core_checker.sv ====
`timescale 1ns/100ps

module core_checker (
    input logic          clk,
    input logic          reset,
    input logic          i_uart_en,
    input rv_pkg::word_t i_pc
);

    // strobe register is cleared by every reset edge
    a_uart_low_in_reset: assert property (@(posedge clk) reset |=> !i_uart_en)
        else $error("uart strobe high after a reset cycle");

    // stores to the uart are at least two instructions apart
    a_uart_single_cycle: assert property (
        @(posedge clk) disable iff (reset) i_uart_en |=> !i_uart_en)
        else $error("uart strobe held for two cycles");

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) i_pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

// ==== testbench/tb_core.sv ====
`timescale 1ns/100ps

module tb_core;
    import rv_pkg::*;

    typedef enum logic [3:0] {
        K_R, K_I, K_BR, K_LD, K_ST, K_JAL, K_JALR, K_LUI, K_AUIPC, K_X0
    } kind_e;

    // rnd bit 0 draws a, bit 1 draws b
    typedef struct packed {
        kind_e kind;
        logic [2:0] f3;
        logic alt;
        logic [1:0] off;
        logic [1:0] rnd;
        word_t a;
        word_t b;
    } row_t;

    localparam int N_ROWS = 42;
    localparam int UART_TIMEOUT = 100;
    localparam int QUIET_CYCLES = 40;
    localparam word_t OP_PC = 32'd24;  // after six prologue words

    row_t rows [N_ROWS] = '{
        '{K_R, 3'd0, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_R, 3'd0, 1'b1, 2'd0, 2'b00, 32'h8000_0000, 32'h0000_0001},
        '{K_R, 3'd1, 1'b0, 2'd0, 2'b01, 32'h0, 32'h0000_0024},  // shift by 36 uses 4
        '{K_R, 3'd2, 1'b0, 2'd0, 2'b00, 32'hffff_ffff, 32'h0000_0001},
        '{K_R, 3'd3, 1'b0, 2'd0, 2'b00, 32'hffff_ffff, 32'h0000_0001},
        '{K_R, 3'd4, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_R, 3'd5, 1'b0, 2'd0, 2'b00, 32'h8000_00f0, 32'h0000_0003},
        '{K_R, 3'd5, 1'b1, 2'd0, 2'b00, 32'h8000_00f0, 32'h0000_003f},
        '{K_R, 3'd6, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_R, 3'd7, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_I, 3'd0, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_I, 3'd2, 1'b0, 2'd0, 2'b00, 32'hffff_fff0, 32'h0000_0fff},
        '{K_I, 3'd3, 1'b0, 2'd0, 2'b00, 32'h0000_0005, 32'h0000_0fff},
        '{K_I, 3'd4, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_I, 3'd6, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_I, 3'd7, 1'b0, 2'd0, 2'b11, 32'h0, 32'h0},
        '{K_I, 3'd1, 1'b0, 2'd0, 2'b01, 32'h0, 32'h0000_001f},
        '{K_I, 3'd5, 1'b0, 2'd0, 2'b01, 32'h0, 32'h0000_0007},
        '{K_I, 3'd5, 1'b1, 2'd0, 2'b00, 32'h8000_1234, 32'h0000_000c},
        '{K_BR, 3'd0, 1'b0, 2'd0, 2'b00, 32'h1234_5678, 32'h1234_5678},
        '{K_BR, 3'd1, 1'b0, 2'd0, 2'b00, 32'h1234_5678, 32'h1234_5678},
        '{K_BR, 3'd4, 1'b0, 2'd0, 2'b00, 32'hffff_ffff, 32'h0000_0001},
        '{K_BR, 3'd5, 1'b0, 2'd0, 2'b00, 32'hffff_ffff, 32'h0000_0001},
        '{K_BR, 3'd6, 1'b0, 2'd0, 2'b00, 32'hffff_ffff, 32'h0000_0001},
        '{K_BR, 3'd7, 1'b0, 2'd0, 2'b00, 32'hffff_ffff, 32'h0000_0001},
        '{K_LD, 3'd0, 1'b0, 2'd0, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd0, 1'b0, 2'd1, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd0, 1'b0, 2'd2, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd0, 1'b0, 2'd3, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd4, 1'b0, 2'd3, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd1, 1'b0, 2'd0, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd1, 1'b0, 2'd2, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd5, 1'b0, 2'd2, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_LD, 3'd2, 1'b0, 2'd0, 2'b00, 32'h8a7f_f015, 32'h0},
        '{K_ST, 3'd0, 1'b0, 2'd1, 2'b10, 32'h1122_3344, 32'h0},
        '{K_ST, 3'd1, 1'b0, 2'd2, 2'b10, 32'h1122_3344, 32'h0},
        '{K_ST, 3'd0, 1'b0, 2'd3, 2'b11, 32'h0, 32'h0},
        '{K_JAL, 3'd0, 1'b0, 2'd0, 2'b00, 32'h0, 32'h0},
        '{K_JALR, 3'd0, 1'b0, 2'd0, 2'b00, 32'h0, 32'h0},
        '{K_LUI, 3'd0, 1'b0, 2'd0, 2'b01, 32'h0, 32'h0},
        '{K_AUIPC, 3'd0, 1'b0, 2'd0, 2'b00, 32'habcd_e000, 32'h0},
        '{K_X0, 3'd0, 1'b0, 2'd0, 2'b10, 32'h0, 32'h0}
    };

    logic clk;
    logic por_reset;
    logic load_hold = 1'b1;
    logic reset;
    logic load_en = 1'b0;
    mem_addr_t load_addr = '0;
    word_t load_data = '0;
    logic uart_en;
    byte_t uart_data;

    word_t prog[$];
    logic [31:0] lfsr_state = 32'd53;
    int error_count = 0;
    int failed_tests = 0;

    assign reset = por_reset | load_hold;  // program loads only while reset is high

    tb_clock u_clock (
        .o_clk   (clk),
        .o_reset (por_reset)
    );

    rv_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .i_load_en   (load_en),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .o_uart_en   (uart_en),
        .o_uart_data (uart_data)
    );

    bind rv_core core_checker u_checker (
        .clk       (clk),
        .reset     (reset),
        .i_uart_en (o_uart_en),
        .i_pc      (pc)
    );

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_word(output word_t w);
        for (int i = 0; i < XLEN; i++) begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: return (x < y) ? 32'd1 : 32'd0;
            3'd4: return x ^ y;
            3'd5: begin
                if (alt) return $signed(x) >>> y[4:0];
                else return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t x, word_t y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd4: return $signed(x) < $signed(y);
            3'd5: return !($signed(x) < $signed(y));
            3'd6: return x < y;
            default: return !(x < y);
        endcase
    endfunction

    function automatic word_t ref_result(row_t r, word_t a, word_t b);
        word_t imm;
        word_t sh;
        word_t m;
        int o;
        imm = {{20{b[11]}}, b[11:0]};
        sh = a >> {r.off, 3'b000};
        m = a;
        o = int'(r.off);
        case (r.kind)
            K_R: return alu_ref(r.f3, r.alt, a, b);
            K_I: return alu_ref(r.f3, r.alt, a, imm);
            K_BR: return branch_taken(r.f3, a, b) ? 32'd1 : 32'd0;
            K_LD: begin
                case (r.f3)
                    3'd0: return {{24{sh[7]}}, sh[7:0]};
                    3'd4: return {24'd0, sh[7:0]};
                    3'd1: return {{16{sh[15]}}, sh[15:0]};
                    3'd5: return {16'd0, sh[15:0]};
                    default: return a;
                endcase
            end
            K_ST: begin
                if (r.f3 == 3'd0) m[8*o +: 8] = b[7:0];
                else m[16*(o/2) +: 16] = b[15:0];
                return m;
            end
            K_JAL: return OP_PC + 32'd4;
            K_JALR: return OP_PC + 32'd8;
            K_LUI: return {a[31:12], 12'h000};
            K_AUIPC: return OP_PC + {a[31:12], 12'h000};
            default: return b;  // x0 stays zero, so x3 = 0 + b
        endcase
    endfunction

    // lui plus addi, hi rounded for the sign of the low part
    task automatic push_const(input reg_idx_t rd, input word_t v);
        word_t hi;
        hi = v + 32'h800;
        prog.push_back(enc_u(hi[31:12], rd, OPC_LUI));
        prog.push_back(enc_i(v[11:0], rd, 3'd0, rd, OPC_OP_IMM));
    endtask

    task automatic build_program(input row_t r, input word_t a, input word_t b);
        logic [11:0] imm;
        prog.delete();
        push_const(5'd1, a);
        push_const(5'd2, b);
        push_const(5'd4, UART_TX_ADDR);
        imm = (r.f3 == 3'd1 || r.f3 == 3'd5) ? {1'b0, r.alt, 5'd0, b[4:0]} : b[11:0];
        case (r.kind)
            K_R: prog.push_back(enc_r({1'b0, r.alt, 5'd0}, 5'd2, 5'd1, r.f3, 5'd3));
            K_I: prog.push_back(enc_i(imm, 5'd1, r.f3, 5'd3, OPC_OP_IMM));
            K_BR: begin
                prog.push_back(enc_i(12'd1, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
                prog.push_back(enc_b(13'd8, 5'd2, 5'd1, r.f3));
                prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));  // skipped if taken
            end
            K_LD: begin
                prog.push_back(enc_s(12'h400, 5'd1, 5'd0, 3'd2));
                prog.push_back(enc_i({10'h100, r.off}, 5'd0, r.f3, 5'd3, OPC_LOAD));
            end
            K_ST: begin
                prog.push_back(enc_s(12'h400, 5'd1, 5'd0, 3'd2));
                prog.push_back(enc_s({10'h100, r.off}, 5'd2, 5'd0, r.f3));
                prog.push_back(enc_i(12'h400, 5'd0, 3'd2, 5'd3, OPC_LOAD));
            end
            K_JAL: begin
                prog.push_back(enc_j(21'd8, 5'd3));
                prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
            end
            K_JALR: begin
                prog.push_back(enc_i(12'd37, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));  // odd target
                prog.push_back(enc_i(12'd0, 5'd5, 3'd0, 5'd3, OPC_JALR));
                prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
            end
            K_LUI: prog.push_back(enc_u(a[31:12], 5'd3, OPC_LUI));
            K_AUIPC: prog.push_back(enc_u(a[31:12], 5'd3, OPC_AUIPC));
            default: begin
                prog.push_back(enc_i(12'd5, 5'd1, 3'd0, 5'd0, OPC_OP_IMM));
                prog.push_back(enc_r(7'd0, 5'd2, 5'd0, 3'd0, 5'd3));
            end
        endcase
        // uart byte stores also land in word 8 and must find it already executed
        while (prog.size() < 9) begin
            prog.push_back(enc_i(12'd0, 5'd0, 3'd0, 5'd0, OPC_OP_IMM));
        end
        for (int k = 0; k < 4; k++) begin
            prog.push_back(enc_s(12'd0, 5'd3, 5'd4, 3'd0));
            prog.push_back(enc_i(12'd8, 5'd3, 3'd5, 5'd3, OPC_OP_IMM));
        end
        prog.push_back(enc_j(21'd0, 5'd0));  // park here
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_byte(input byte_t got, input byte_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic run_test(input int t);
        row_t r;
        word_t a;
        word_t b;
        word_t exp;
        word_t got;
        int wait_cnt;
        int errs_before;
        logic ok;
        r = rows[t];
        a = r.a;
        b = r.b;
        if (r.rnd[0]) draw_word(a);
        if (r.rnd[1]) draw_word(b);
        build_program(r, a, b);
        exp = ref_result(r, a, b);
        errs_before = error_count;
        ok = 1'b1;
        got = '0;

        @(posedge clk);
        load_hold <= 1'b1;
        foreach (prog[i]) begin
            load_en <= 1'b1;
            load_addr <= mem_addr_t'(i);
            load_data <= prog[i];
            @(posedge clk);
        end
        load_en <= 1'b0;
        @(posedge clk);
        load_hold <= 1'b0;

        for (int k = 0; k < 4 && ok; k++) begin
            wait_cnt = 0;
            do begin
                @(negedge clk);
                wait_cnt++;
            end while (!uart_en && wait_cnt < UART_TIMEOUT);
            if (!uart_en) begin
                $display("test %0d: no UART byte %0d within %0d cycles", t, k, UART_TIMEOUT);
                error_count++;
                ok = 1'b0;
            end else begin
                check_byte(uart_data, exp[8*k +: 8], "o_uart_data");
                got[8*k +: 8] = uart_data;
            end
        end
        if (ok) begin
            for (int c = 0; c < QUIET_CYCLES; c++) begin
                @(negedge clk);
                if (uart_en && ok) begin
                    $display("test %0d: UART strobe after the fourth byte", t);
                    error_count++;
                    ok = 1'b0;
                end
            end
            check_word(got, exp, "uart word");
        end
        if (error_count != errs_before) failed_tests++;
        $display("test %0d %s a=%h b=%h expected %h: %s", t, r.kind.name(), a, b, exp,
                 (error_count == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        for (int t = 0; t < N_ROWS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", N_ROWS, failed_tests, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/rv_pkg.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_mem.sv
src/rv_result.sv
src/rv_core.sv
testbench/tb_clock.sv
testbench/core_checker.sv
testbench/tb_core.sv

// ==== run.sh ====
#!/bin/bash
# build and run the core testbench with Verilator
set -e
set -o pipefail

verilator --binary --assert --top-module tb_core -f list.f -o sim_tb_core
./obj_dir/sim_tb_core | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
